/* Bender.yml */
package:
  name: sdram_ctrl

sources:
  - sdram_ctrl_pkg.sv
  - sdram_bus_pkg.sv
  - sdram_fsm.sv
  - sdram_init.sv
  - sdram_refresh.sv
  - sdram_burst.sv
  - sdram_cmd_mux.sv
  - sdram_ctrl.sv
  - target: simulation
    files:
      - tb_sdram_ctrl.sv

/* sdram_burst.sv */
`timescale 1ns/1ns

module sdram_burst #(
	parameter bit IS_WRITE  = 1'b1,
	parameter int BURST_LEN = 64,
	parameter int T_RCD     = 2,
	parameter int T_RP      = 2
) (
	input  logic                      pi_clk,
	input  logic                      pi_rst_n,
	input  logic                      run,
	input  sdram_ctrl_pkg::row_t      row,
	input  sdram_ctrl_pkg::data_t     fifo_data,
	input  sdram_ctrl_pkg::data_t     dq_in,
	output logic                      done,
	output logic                      fifo_req,
	output sdram_ctrl_pkg::data_t     fifo_wdata,
	output sdram_bus_pkg::sdram_bus_t bus
);
	import sdram_ctrl_pkg::*;
	import sdram_bus_pkg::*;

	localparam int RW_AT   = T_RCD;
	localparam int STOP_AT = RW_AT + BURST_LEN;
	localparam int PRE_AT  = IS_WRITE ? STOP_AT + 1 : STOP_AT + 1 + CAS_LATENCY;
	localparam int DONE_AT = PRE_AT + T_RP;
	// writes pop one cycle ahead of the data slot, reads push after the mux stage and CAS latency.
	localparam int REQ_LO  = IS_WRITE ? RW_AT - 1 : RW_AT + CAS_LATENCY + 1;
	localparam int REQ_HI  = REQ_LO + BURST_LEN;
	localparam int CW      = $clog2(DONE_AT + 2);

	logic [CW-1:0] cnt;

	always_ff @(posedge pi_clk or negedge pi_rst_n)
	begin
		if (!pi_rst_n)
			cnt <= '0;
		else if (!run)
			cnt <= '0;
		else
			cnt <= cnt + 1'b1;
	end

	assign done       = run && (cnt == CW'(DONE_AT));
	assign fifo_req   = run && (cnt >= CW'(REQ_LO)) && (cnt < CW'(REQ_HI));
	assign fifo_wdata = dq_in;

	always_comb
	begin
		bus = BUS_IDLE;
		if (run)
		begin
			if (cnt == '0)
			begin
				bus.cmd  = cmd_active;
				bus.addr = row;
			end
			else if (cnt == CW'(RW_AT))
			begin
				if (IS_WRITE)
					bus.cmd = cmd_write;
				else
					bus.cmd = cmd_read;
			end
			else if (cnt == CW'(STOP_AT))
				bus.cmd = cmd_burst_stop;
			else if (cnt == CW'(PRE_AT))
				bus.cmd = cmd_precharge; // bank 0 only, so a10 stays low.
			if (IS_WRITE && cnt >= CW'(RW_AT) && cnt < CW'(STOP_AT))
			begin
				bus.dq_out = fifo_data;
				bus.dq_oe  = 1'b1;
			end
		end
	end

	// a FIFO strobe is always followed by at least one more cycle of the burst.
	a_req_in_run: assert property (@(posedge pi_clk) disable iff (!pi_rst_n)
		fifo_req |-> run ##1 run);

endmodule

/* sdram_bus_pkg.sv */
package sdram_bus_pkg;

	// encoding is {cs_n, ras_n, cas_n, we_n}.
	typedef enum logic [3:0] {
		cmd_load_mode  = 4'b0000,
		cmd_refresh    = 4'b0001,
		cmd_precharge  = 4'b0010,
		cmd_active     = 4'b0011,
		cmd_write      = 4'b0100,
		cmd_read       = 4'b0101,
		cmd_burst_stop = 4'b0110,
		cmd_nop        = 4'b0111
	} sdram_cmd_e;

	typedef struct packed {
		sdram_cmd_e            cmd;
		logic [1:0]            ba;
		logic [11:0]           addr;
		sdram_ctrl_pkg::data_t dq_out;
		logic                  dq_oe;
	} sdram_bus_t;

	localparam sdram_bus_t BUS_IDLE = '{
		cmd:    cmd_nop,
		ba:     2'b00,
		addr:   12'h000,
		dq_out: 16'h0000,
		dq_oe:  1'b0
	};

endpackage

/* sdram_cmd_mux.sv */
`timescale 1ns/1ns

module sdram_cmd_mux (
	input  logic                      pi_clk,
	input  logic                      pi_rst_n,
	input  sdram_ctrl_pkg::bus_sel_e  bus_sel,
	input  sdram_bus_pkg::sdram_bus_t init_bus,
	input  sdram_bus_pkg::sdram_bus_t ref_bus,
	input  sdram_bus_pkg::sdram_bus_t wr_bus,
	input  sdram_bus_pkg::sdram_bus_t rd_bus,
	output sdram_bus_pkg::sdram_bus_t sdram_bus
);
	import sdram_ctrl_pkg::*;
	import sdram_bus_pkg::*;

	always_ff @(posedge pi_clk or negedge pi_rst_n)
	begin
		if (!pi_rst_n)
			sdram_bus <= BUS_IDLE;
		else
		begin
			case (bus_sel)
				sel_init:    sdram_bus <= init_bus;
				sel_refresh: sdram_bus <= ref_bus;
				sel_write:   sdram_bus <= wr_bus;
				sel_read:    sdram_bus <= rd_bus;
				default:     sdram_bus <= BUS_IDLE;
			endcase
		end
	end

endmodule

/* sdram_ctrl.f */
sdram_ctrl_pkg.sv
sdram_bus_pkg.sv
sdram_fsm.sv
sdram_init.sv
sdram_refresh.sv
sdram_burst.sv
sdram_cmd_mux.sv
sdram_ctrl.sv
tb_sdram_ctrl.sv

/* sdram_ctrl.sv */
`timescale 1ns/1ns

module sdram_ctrl #(
	parameter int MAX_ROW      = 960,
	parameter int BURST_LEN    = 64,
	parameter int RD_LOW       = 150,
	parameter int WR_HIGH      = 340,
	parameter int REF_INTERVAL = 1560,
	parameter int T_PWR        = 200,
	parameter int T_RP         = 2,
	parameter int T_RFC        = 7,
	parameter int T_RCD        = 2
) (
	input  logic                        pi_clk,
	input  logic                        pi_rst_n,
	input  sdram_ctrl_pkg::fifo_level_t wr_fifo_rusedw,
	input  sdram_ctrl_pkg::data_t       wr_fifo_rdata,
	output logic                        wr_fifo_rdreq,
	input  sdram_ctrl_pkg::fifo_level_t rd_fifo_wusedw,
	output sdram_ctrl_pkg::data_t       rd_fifo_wdata,
	output logic                        rd_fifo_wrreq,
	output sdram_bus_pkg::sdram_bus_t   sdram_bus,
	input  sdram_ctrl_pkg::data_t       sdram_dq_in
);
	import sdram_ctrl_pkg::*;
	import sdram_bus_pkg::*;

	logic       init_run;
	logic       init_done;
	logic       ref_run;
	logic       ref_req;
	logic       ref_done;
	logic       wr_run;
	logic       wr_done;
	logic       rd_run;
	logic       rd_done;
	bus_sel_e   bus_sel;
	row_t       wr_row;
	row_t       rd_row;
	sdram_bus_t init_bus;
	sdram_bus_t ref_bus;
	sdram_bus_t wr_bus;
	sdram_bus_t rd_bus;

	sdram_fsm #(.MAX_ROW(MAX_ROW), .RD_LOW(RD_LOW), .WR_HIGH(WR_HIGH)) i_fsm (
		.pi_clk, .pi_rst_n, .init_done, .ref_req, .ref_done, .wr_done, .rd_done,
		.wr_fifo_rusedw, .rd_fifo_wusedw, .init_run, .ref_run, .wr_run, .rd_run,
		.bus_sel, .wr_row, .rd_row
	);

	sdram_init #(.T_PWR(T_PWR), .T_RP(T_RP), .T_RFC(T_RFC)) i_init (
		.pi_clk, .pi_rst_n, .run(init_run), .done(init_done), .bus(init_bus)
	);

	sdram_refresh #(.REF_INTERVAL(REF_INTERVAL), .T_RFC(T_RFC)) i_refresh (
		.pi_clk, .pi_rst_n, .run(ref_run), .req(ref_req), .done(ref_done), .bus(ref_bus)
	);

	sdram_burst #(.IS_WRITE(1'b1), .BURST_LEN(BURST_LEN), .T_RCD(T_RCD), .T_RP(T_RP)) i_wr (
		.pi_clk, .pi_rst_n, .run(wr_run), .row(wr_row), .fifo_data(wr_fifo_rdata),
		.dq_in(sdram_dq_in), .done(wr_done), .fifo_req(wr_fifo_rdreq), .fifo_wdata(),
		.bus(wr_bus)
	);

	sdram_burst #(.IS_WRITE(1'b0), .BURST_LEN(BURST_LEN), .T_RCD(T_RCD), .T_RP(T_RP)) i_rd (
		.pi_clk, .pi_rst_n, .run(rd_run), .row(rd_row), .fifo_data('0),
		.dq_in(sdram_dq_in), .done(rd_done), .fifo_req(rd_fifo_wrreq),
		.fifo_wdata(rd_fifo_wdata), .bus(rd_bus)
	);

	sdram_cmd_mux i_mux (
		.pi_clk, .pi_rst_n, .bus_sel, .init_bus, .ref_bus, .wr_bus, .rd_bus, .sdram_bus
	);

endmodule

/* sdram_ctrl_pkg.sv */
package sdram_ctrl_pkg;

	typedef logic [11:0] row_t;        // one SDRAM row address.
	typedef logic [8:0]  fifo_level_t; // used-word count of a FIFO.
	typedef logic [15:0] data_t;       // pixel word, same width as the SDRAM data bus.

	typedef enum logic [1:0] {
		sel_init    = 2'b00,
		sel_refresh = 2'b01,
		sel_write   = 2'b10,
		sel_read    = 2'b11
	} bus_sel_e;

	typedef enum logic [2:0] {
		st_init,
		st_refresh,
		st_idle,
		st_rd_row,
		st_rd_wait,
		st_wr_row,
		st_wr_wait
	} arb_state_e;

	localparam int CAS_LATENCY = 2;

	// Fields from bit 11 down: reserved, write burst mode, operating mode,
	// CAS latency, sequential order, full-page burst.
	localparam logic [11:0] MODE_WORD = {
		2'b00,
		1'b0,
		2'b00,
		3'(CAS_LATENCY),
		1'b0,
		3'b111
	};

endpackage

/* sdram_fsm.sv */
`timescale 1ns/1ns

module sdram_fsm #(
	parameter int MAX_ROW = 960,
	parameter int RD_LOW  = 150,
	parameter int WR_HIGH = 340
) (
	input  logic                         pi_clk,
	input  logic                         pi_rst_n,
	input  logic                         init_done,
	input  logic                         ref_req,
	input  logic                         ref_done,
	input  logic                         wr_done,
	input  logic                         rd_done,
	input  sdram_ctrl_pkg::fifo_level_t  wr_fifo_rusedw,
	input  sdram_ctrl_pkg::fifo_level_t  rd_fifo_wusedw,
	output logic                         init_run,
	output logic                         ref_run,
	output logic                         wr_run,
	output logic                         rd_run,
	output sdram_ctrl_pkg::bus_sel_e     bus_sel,
	output sdram_ctrl_pkg::row_t         wr_row,
	output sdram_ctrl_pkg::row_t         rd_row
);
	import sdram_ctrl_pkg::*;

	arb_state_e state;

	always_ff @(posedge pi_clk or negedge pi_rst_n)
	begin
		if (!pi_rst_n)
		begin
			state    <= st_init;
			init_run <= 1'b0;
			ref_run  <= 1'b0;
			wr_run   <= 1'b0;
			rd_run   <= 1'b0;
			bus_sel  <= sel_init;
			wr_row   <= '0;
			rd_row   <= '0;
		end
		else
		begin
			case (state)
				st_init:
				begin
					if (!init_done)
						init_run <= 1'b1;
					else
					begin
						init_run <= 1'b0;
						bus_sel  <= sel_refresh; // one refresh always follows power-up.
						state    <= st_refresh;
					end
				end
				st_refresh:
				begin
					if (!ref_done)
						ref_run <= 1'b1;
					else
					begin
						ref_run <= 1'b0;
						state   <= st_idle;
					end
				end
				st_idle:
				begin
					if (ref_req)
					begin
						bus_sel <= sel_refresh;
						state   <= st_refresh;
					end
					else if (rd_fifo_wusedw < fifo_level_t'(RD_LOW))
					begin
						bus_sel <= sel_read;
						state   <= st_rd_row;
					end
					else if (wr_fifo_rusedw > fifo_level_t'(WR_HIGH))
					begin
						bus_sel <= sel_write;
						state   <= st_wr_row;
					end
				end
				st_rd_row:
				begin
					rd_row <= (rd_row < row_t'(MAX_ROW)) ? rd_row + 1'b1 : row_t'(1);
					state  <= st_rd_wait;
				end
				st_rd_wait:
				begin
					if (!rd_done)
						rd_run <= 1'b1;
					else
					begin
						rd_run <= 1'b0;
						state  <= st_idle;
					end
				end
				st_wr_row:
				begin
					wr_row <= (wr_row < row_t'(MAX_ROW)) ? wr_row + 1'b1 : row_t'(1);
					state  <= st_wr_wait;
				end
				st_wr_wait:
				begin
					if (!wr_done)
						wr_run <= 1'b1;
					else
					begin
						wr_run <= 1'b0;
						state  <= st_idle;
					end
				end
				default: state <= st_init;
			endcase
		end
	end

	// only one sequencer may own the pins at a time.
	a_one_run: assert property (@(posedge pi_clk) disable iff (!pi_rst_n)
		$onehot0({init_run, ref_run, wr_run, rd_run}));

	// the mux select must not move under a running sequencer.
	a_sel_stable: assert property (@(posedge pi_clk) disable iff (!pi_rst_n)
		(init_run || ref_run || wr_run || rd_run) |-> $stable(bus_sel));

endmodule

/* sdram_init.sv */
`timescale 1ns/1ns

module sdram_init #(
	parameter int T_PWR = 200,
	parameter int T_RP  = 2,
	parameter int T_RFC = 7
) (
	input  logic                      pi_clk,
	input  logic                      pi_rst_n,
	input  logic                      run,
	output logic                      done,
	output sdram_bus_pkg::sdram_bus_t bus
);
	import sdram_ctrl_pkg::*;
	import sdram_bus_pkg::*;

	localparam int PRE_AT  = T_PWR;
	localparam int REF1_AT = PRE_AT + T_RP;
	localparam int REF2_AT = REF1_AT + T_RFC;
	localparam int LMR_AT  = REF2_AT + T_RFC;
	localparam int DONE_AT = LMR_AT + 1;
	localparam int CW      = $clog2(DONE_AT + 2);

	logic [CW-1:0] cnt;

	always_ff @(posedge pi_clk or negedge pi_rst_n)
	begin
		if (!pi_rst_n)
			cnt <= '0;
		else if (!run)
			cnt <= '0;
		else
			cnt <= cnt + 1'b1;
	end

	assign done = run && (cnt == CW'(DONE_AT));

	always_comb
	begin
		bus = BUS_IDLE;
		if (run)
		begin
			if (cnt == CW'(PRE_AT))
			begin
				bus.cmd  = cmd_precharge;
				bus.addr = 12'h400; // a10 high selects all banks.
			end
			else if (cnt == CW'(REF1_AT) || cnt == CW'(REF2_AT))
				bus.cmd = cmd_refresh;
			else if (cnt == CW'(LMR_AT))
			begin
				bus.cmd  = cmd_load_mode;
				bus.addr = MODE_WORD;
			end
		end
	end

endmodule

/* sdram_refresh.sv */
`timescale 1ns/1ns

module sdram_refresh #(
	parameter int REF_INTERVAL = 1560,
	parameter int T_RFC        = 7
) (
	input  logic                      pi_clk,
	input  logic                      pi_rst_n,
	input  logic                      run,
	output logic                      req,
	output logic                      done,
	output sdram_bus_pkg::sdram_bus_t bus
);
	import sdram_bus_pkg::*;

	localparam int TW = $clog2(REF_INTERVAL + 1);
	localparam int CW = $clog2(T_RFC + 2);

	logic [CW-1:0] cnt;
	logic [TW-1:0] timer;
	logic          started; // set by the first completed refresh.

	always_ff @(posedge pi_clk or negedge pi_rst_n)
	begin
		if (!pi_rst_n)
			cnt <= '0;
		else if (!run)
			cnt <= '0;
		else
			cnt <= cnt + 1'b1;
	end

	always_ff @(posedge pi_clk or negedge pi_rst_n)
	begin
		if (!pi_rst_n)
		begin
			timer   <= '0;
			started <= 1'b0;
		end
		else if (done)
		begin
			timer   <= '0;
			started <= 1'b1;
		end
		else if (started && timer != TW'(REF_INTERVAL))
			timer <= timer + 1'b1;
	end

	assign req  = (timer == TW'(REF_INTERVAL)); // held until the refresh is served.
	assign done = run && (cnt == CW'(T_RFC));

	always_comb
	begin
		bus = BUS_IDLE;
		if (run && cnt == '0)
			bus.cmd = cmd_refresh;
	end

endmodule

/* tb_sdram_ctrl.sv */
`timescale 1ns/1ns

module tb_sdram_ctrl;
	import sdram_ctrl_pkg::*;
	import sdram_bus_pkg::*;

	localparam int REF_INTERVAL = 400;
	localparam int BURST_LEN    = 64;
	localparam int MAX_ROW      = 960;
	localparam int RD_LOW       = 150;
	localparam int WR_HIGH      = 340;
	localparam int T_RFC        = 7;
	localparam int T_RCD        = 2;
	localparam int T_RP         = 2;
	localparam int RD_BURST     = 2 + T_RCD + BURST_LEN + T_RP + CAS_LATENCY;
	localparam int ARB_SLACK    = 10; // row, wait and idle steps of the arbiter around a burst.
	localparam int REF_MAX_GAP  = REF_INTERVAL + RD_BURST + T_RFC + ARB_SLACK;
	localparam int ARB_TO_PIN   = 4;  // idle decision, row update, run rise, pin register.
	localparam int N_BURSTS     = 60;
	// full-page burst, sequential order, CAS latency in bits 6:4.
	localparam logic [11:0] EXP_MODE = {5'b00000, 3'(CAS_LATENCY), 1'b0, 3'b111};

	typedef struct packed {
		fifo_level_t wr;
		fifo_level_t rd;
	} levels_t;

	logic        pi_clk;
	logic        pi_rst_n;
	fifo_level_t wr_fifo_rusedw;
	data_t       wr_fifo_rdata;
	logic        wr_fifo_rdreq;
	fifo_level_t rd_fifo_wusedw;
	data_t       rd_fifo_wdata;
	logic        rd_fifo_wrreq;
	sdram_bus_t  sdram_bus;
	data_t       sdram_dq_in;

	data_t       mem [int]; // keyed by row * 256 + column.
	data_t       exp_wr [$];
	data_t       exp_rd [$];
	data_t       dq_pipe [$];
	levels_t     lvl_hist [$];
	sdram_cmd_e  init_cmds [4];
	int          init_seen;
	int          bursts;
	int          cycle;
	int          stim_cnt;
	int          last_ref;
	int          col;
	int          words;
	logic        bank_open;
	logic        open_is_rd;
	logic        reading;
	row_t        open_row;
	row_t        wr_exp_row;
	row_t        rd_exp_row;

	sdram_ctrl #(.T_PWR(20), .REF_INTERVAL(REF_INTERVAL)) i_dut (
		.pi_clk, .pi_rst_n, .wr_fifo_rusedw, .wr_fifo_rdata, .wr_fifo_rdreq,
		.rd_fifo_wusedw, .rd_fifo_wdata, .rd_fifo_wrreq, .sdram_bus, .sdram_dq_in
	);

	initial
	begin
		pi_clk = 1'b0;
		forever #10 pi_clk = ~pi_clk;
	end

	task automatic stop_with_failure(input string what);
		$display("%s", what);
		$display("TB FAILED");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
			stop_with_failure($sformatf("ERROR at %0t: %s expected %0h got %0h",
				$time, name, expected, actual));
	endtask

	function automatic row_t next_row(input row_t r);
		return (r == row_t'(MAX_ROW)) ? row_t'(1) : r + 1'b1;
	endfunction

	function automatic data_t mem_read(input row_t r, input int c);
		if (mem.exists(int'(r) * 256 + c))
			return mem[int'(r) * 256 + c];
		return '0; // rows never written read back as zero.
	endfunction

	// the write FIFO answers each read request one cycle later.
	task automatic next_cycle();
		data_t word;
		@(posedge pi_clk);
		stim_cnt++;
		if (wr_fifo_rdreq)
		begin
			word = data_t'($urandom);
			wr_fifo_rdata <= word;
			exp_wr.push_back(word);
		end
		if (stim_cnt % 50 == 0)
		begin
			wr_fifo_rusedw <= fifo_level_t'($urandom_range(511));
			rd_fifo_wusedw <= fifo_level_t'($urandom_range(511));
		end
	endtask

	always @(posedge pi_clk)
	begin : monitor
		levels_t now;
		levels_t at_decision;
		data_t   rd_word;
		if (pi_rst_n)
		begin
			cycle++;
			now.wr = wr_fifo_rusedw;
			now.rd = rd_fifo_wusedw;
			lvl_hist.push_back(now);
			if (lvl_hist.size() > 8)
				void'(lvl_hist.pop_front());
			if (sdram_bus.cmd != cmd_nop && init_seen < 4)
			begin
				check("sdram_bus.cmd", init_cmds[init_seen], sdram_bus.cmd);
				if (sdram_bus.cmd == cmd_precharge)
					check("sdram_bus.addr[10]", 1'b1, sdram_bus.addr[10]);
				if (sdram_bus.cmd == cmd_load_mode)
					check("sdram_bus.addr", EXP_MODE, sdram_bus.addr);
				init_seen++;
			end
			else
			begin
				case (sdram_bus.cmd)
					cmd_active:
					begin
						if (bank_open)
							stop_with_failure("activate issued while a row was still open");
						check("sdram_bus.ba", 2'b00, sdram_bus.ba);
						at_decision = lvl_hist[$ - ARB_TO_PIN];
						if (at_decision.rd < fifo_level_t'(RD_LOW))
						begin
							rd_exp_row = next_row(rd_exp_row);
							open_is_rd = 1'b1;
							check("sdram_bus.addr", rd_exp_row, sdram_bus.addr);
						end
						else if (at_decision.wr > fifo_level_t'(WR_HIGH))
						begin
							wr_exp_row = next_row(wr_exp_row);
							open_is_rd = 1'b0;
							check("sdram_bus.addr", wr_exp_row, sdram_bus.addr);
						end
						else
							stop_with_failure("activate issued with no FIFO level calling for it");
						open_row  = sdram_bus.addr;
						bank_open = 1'b1;
						words     = 0;
					end
					cmd_read, cmd_write:
					begin
						if (!bank_open)
							stop_with_failure("read or write issued with no open row");
						check("sdram_bus.ba", 2'b00, sdram_bus.ba);
						check("burst direction", open_is_rd, sdram_bus.cmd == cmd_read);
						col = 0;
						if (sdram_bus.cmd == cmd_read)
						begin
							reading = 1'b1;
							for (int i = 0; i < BURST_LEN; i++)
								exp_rd.push_back(mem_read(open_row, i));
						end
					end
					cmd_burst_stop: reading = 1'b0;
					cmd_refresh:
					begin
						if (bank_open)
							stop_with_failure("refresh issued while a burst was open");
						if (last_ref >= 0 && cycle - last_ref > REF_MAX_GAP)
							stop_with_failure($sformatf("refresh gap of %0d cycles is too long",
								cycle - last_ref));
						last_ref = cycle;
					end
					cmd_precharge:
					begin
						if (!bank_open)
							stop_with_failure("precharge issued with no open row");
						if (open_is_rd)
							check("read words left", 0, exp_rd.size());
						else
							check("write words", BURST_LEN, words);
						bank_open = 1'b0;
						bursts++;
					end
					cmd_load_mode: stop_with_failure("load-mode issued after init");
					default: ;
				endcase
			end
			if (sdram_bus.dq_oe)
			begin
				if (!bank_open || open_is_rd || exp_wr.size() == 0)
					stop_with_failure("write data on the pins with no write burst behind it");
				check("sdram_bus.dq_out", exp_wr.pop_front(), sdram_bus.dq_out);
				mem[int'(open_row) * 256 + col] = sdram_bus.dq_out;
				col++;
				words++;
			end
			// the word fetched in this pin cycle reaches dq CAS_LATENCY cycles later.
			rd_word = '0;
			if (reading)
			begin
				rd_word = mem_read(open_row, col);
				col++;
			end
			dq_pipe.push_back(rd_word);
			sdram_dq_in <= dq_pipe.pop_front();
			if (rd_fifo_wrreq)
			begin
				if (exp_rd.size() == 0)
					stop_with_failure("read FIFO push with no read word expected");
				check("rd_fifo_wdata", exp_rd.pop_front(), rd_fifo_wdata);
			end
		end
	end

	initial
	begin
		int waited;
		void'($urandom(32'h5957a87f));
		pi_rst_n       = 1'b0;
		wr_fifo_rusedw = '0;
		rd_fifo_wusedw = '1; // no burst is called for until the first draw.
		wr_fifo_rdata  = '0;
		sdram_dq_in    = '0;
		init_cmds[0]   = cmd_precharge;
		init_cmds[1]   = cmd_refresh;
		init_cmds[2]   = cmd_refresh;
		init_cmds[3]   = cmd_load_mode;
		init_seen      = 0;
		bursts         = 0;
		cycle          = 0;
		stim_cnt       = 0;
		last_ref       = -1;
		col            = 0;
		words          = 0;
		bank_open      = 1'b0;
		open_is_rd     = 1'b0;
		reading        = 1'b0;
		open_row       = '0;
		wr_exp_row     = '0;
		rd_exp_row     = '0;
		repeat (CAS_LATENCY - 1)
			dq_pipe.push_back('0);
		repeat (5)
			next_cycle();
		check("sdram_bus.cmd", cmd_nop, sdram_bus.cmd);
		check("sdram_bus.dq_oe", 1'b0, sdram_bus.dq_oe);
		pi_rst_n <= 1'b1;
		waited = 0;
		while (init_seen < 4)
		begin
			next_cycle();
			waited++;
			if (waited > 1000)
				stop_with_failure("timeout while waiting for the init command sequence");
		end
		waited = 0;
		while (bursts < N_BURSTS)
		begin
			next_cycle();
			waited++;
			if (waited > 100000)
				stop_with_failure("timeout while waiting for the bursts to complete");
		end
		$display("TB PASSED");
		$finish;
	end

endmodule
